// ==== rtl/alg_settings.svh ====
/*
 * Addend aligner settings
 * Widths of the double precision datapath and the shift constants
 */
`ifndef ALG_SETTINGS_SVH
`define ALG_SETTINGS_SVH

`define ALG_EXPO_W       13
`define ALG_FRAC_W       53
`define ALG_LVL2_W       68
`define ALG_RES_W        163
`define ALG_SHA_W        15
`define ALG_FINE_W       4
`define ALG_COARSE_W     4

`define ALG_EXPO_BIAS    1023
// Shift that lines B up with a product of the same exponent
`define ALG_SHIFT_OFFSET 56
`define ALG_SHIFT_MAX    162

`endif

// ==== rtl/alg_pkg.sv ====
/*
 * Addend aligner types
 * Vector types for exponents, fractions, shift amounts and results
 */
`include "alg_settings.svh"

package alg_pkg;

   typedef logic [`ALG_EXPO_W-1:0] expo_t;

   // Bit 0 is the most significant bit of the fraction and field types
   typedef logic [0:`ALG_FRAC_W-1] frac_t;
   typedef logic [0:`ALG_LVL2_W-1] lvl2_t;
   typedef logic [0:`ALG_RES_W-1] res_t;

   typedef logic signed [`ALG_SHA_W-1:0] sha_t;

   // Fine shift is 0 to 15 bits, coarse shift counts steps of 16
   typedef logic [`ALG_FINE_W-1:0] fine_t;
   typedef logic [`ALG_COARSE_W-1:0] coarse_t;

endpackage

// ==== rtl/alg_shift_amount.sv ====
/*
 * Aligner shift amount
 * Forms the B shift from the A, C and B exponents, flags out of range
 * shifts and splits the amount into fine and coarse parts
 */
`timescale 1ns/1ns
`include "alg_settings.svh"

module alg_shift_amount (
   input  logic              nclk,
   input  logic              arst_n,
   input  logic              ex2_act,
   input  alg_pkg::expo_t    a_expo,
   input  alg_pkg::expo_t    c_expo,
   input  alg_pkg::expo_t    b_expo,
   output alg_pkg::fine_t    fine,
   output alg_pkg::coarse_t  ex3_coarse,
   output logic              ex3_ovf,
   output logic              ex3_unf
);

   localparam alg_pkg::sha_t sha_adj = alg_pkg::sha_t'(`ALG_SHIFT_OFFSET - `ALG_EXPO_BIAS);
   localparam alg_pkg::sha_t sha_max = alg_pkg::sha_t'(`ALG_SHIFT_MAX);

   alg_pkg::sha_t sha;
   logic          ovf;
   logic          unf;

   function automatic alg_pkg::sha_t expo_ext(input alg_pkg::expo_t e);
      return alg_pkg::sha_t'({{(`ALG_SHA_W - `ALG_EXPO_W){1'b0}}, e});
   endfunction

   // Product exponent minus B exponent, biased so that equal exponents give the offset
   assign sha = expo_ext(a_expo) + expo_ext(c_expo) - expo_ext(b_expo) + sha_adj;

   // A negative amount means B sits left of the product
   assign ovf = sha[`ALG_SHA_W-1];
   assign unf = (sha > sha_max);

   assign fine = sha[`ALG_FINE_W-1:0];

   always_ff @(posedge nclk or negedge arst_n) begin
      if (!arst_n) begin
         ex3_coarse <= '0;
         ex3_ovf    <= 1'b0;
         ex3_unf    <= 1'b0;
      end else if (ex2_act) begin
         ex3_coarse <= sha[`ALG_FINE_W+`ALG_COARSE_W-1:`ALG_FINE_W];
         ex3_ovf    <= ovf;
         ex3_unf    <= unf;
      end
   end

endmodule

// ==== rtl/alg_shift_fine.sv ====
/*
 * Aligner fine shifter
 * Moves the B fraction right by 0 to 15 bits into the ex3 field
 */
`timescale 1ns/1ns
`include "alg_settings.svh"

module alg_shift_fine (
   input  logic            nclk,
   input  logic            arst_n,
   input  logic            ex2_act,
   input  alg_pkg::frac_t  b_frac,
   input  alg_pkg::fine_t  fine,
   output alg_pkg::lvl2_t  ex3_lvl2
);

   logic [0:`ALG_FRAC_W+2] lvl1;
   alg_pkg::lvl2_t         lvl2;

   // First level shifts by 0 to 3
   assign lvl1 = {b_frac, 3'b000} >> fine[1:0];

   // Second level shifts by 0, 4, 8 or 12
   assign lvl2 = {lvl1, 12'h000} >> {fine[3:2], 2'b00};

   always_ff @(posedge nclk or negedge arst_n) begin
      if (!arst_n) begin
         ex3_lvl2 <= '0;
      end else if (ex2_act) begin
         ex3_lvl2 <= lvl2;
      end
   end

endmodule

// ==== rtl/alg_shift_coarse.sv ====
/*
 * Aligner coarse shifter
 * Steps the ex3 field right by multiples of 16 into the result field
 */
`timescale 1ns/1ns
`include "alg_settings.svh"

module alg_shift_coarse (
   input  alg_pkg::lvl2_t    ex3_lvl2,
   input  alg_pkg::coarse_t  ex3_coarse,
   output alg_pkg::res_t     ex3_shifted
);

   localparam int steps = 1 << `ALG_COARSE_W;
   localparam int step_w = 1 << `ALG_FINE_W;

   alg_pkg::res_t field;

   assign field = {ex3_lvl2, {(`ALG_RES_W - `ALG_LVL2_W){1'b0}}};

   // One leg per coarse code, legs past the field end up all zero
   always_comb begin
      ex3_shifted = '0;
      for (int i = 0; i < steps; i++) begin
         if (ex3_coarse == alg_pkg::coarse_t'(i)) begin
            ex3_shifted = field >> (step_w * i);
         end
      end
   end

endmodule

// ==== rtl/alg_sticky.sv ====
/*
 * Aligner sticky bit
 * ORs the B bits that fall off the result field and registers
 * the sticky bit into ex4
 */
`timescale 1ns/1ns
`include "alg_settings.svh"

module alg_sticky (
   input  logic              nclk,
   input  logic              arst_n,
   input  logic              ex2_act,
   input  alg_pkg::lvl2_t    ex3_lvl2,
   input  alg_pkg::coarse_t  ex3_coarse,
   input  logic              ex3_sel_byp,
   input  logic              ex3_sh_unf,
   input  logic              ex3_b_zero,
   output logic              sticky
);

   localparam int step_w = 1 << `ALG_FINE_W;

   logic ex3_act;
   logic lost;
   logic ex3_sticky;

   // Field bit i lands at i + 16 * coarse, anything past the last bit is lost
   always_comb begin
      lost = 1'b0;
      for (int i = 0; i < `ALG_LVL2_W; i++) begin
         if ((i + step_w * int'(ex3_coarse)) > `ALG_SHIFT_MAX) begin
            lost = lost | ex3_lvl2[i];
         end
      end
   end

   // On underflow the whole fraction is gone
   assign ex3_sticky = ~(ex3_sel_byp | ex3_b_zero) & (ex3_sh_unf ? (|ex3_lvl2) : lost);

   always_ff @(posedge nclk or negedge arst_n) begin
      if (!arst_n) begin
         ex3_act <= 1'b0;
      end else begin
         ex3_act <= ex2_act;
      end
   end

   always_ff @(posedge nclk or negedge arst_n) begin
      if (!arst_n) begin
         sticky <= 1'b0;
      end else if (ex3_act) begin
         sticky <= ex3_sticky;
      end
   end

endmodule

// ==== rtl/alg_result_select.sv ====
/*
 * Aligner result select
 * Picks the bypass pattern, zeros or the shifted addend and inverts
 * the result for an effective subtract
 */
`timescale 1ns/1ns
`include "alg_settings.svh"

module alg_result_select (
   input  logic            nclk,
   input  logic            arst_n,
   input  logic            ex2_act,
   input  alg_pkg::frac_t  b_frac,
   input  logic            b_zero,
   input  logic            prod_zero,
   input  logic            effsub,
   input  logic            ex3_ovf,
   input  logic            ex3_unf,
   input  alg_pkg::res_t   ex3_shifted,
   output alg_pkg::res_t   res,
   output logic            sel_byp,
   output logic            sh_ovf,
   output logic            sh_unf,
   output logic            prod_z,
   output logic            effsub_eac_b,
   output logic            ex3_b_zero
);

   alg_pkg::frac_t ex3_b_frac;
   logic           ex3_effsub;
   alg_pkg::res_t  base;

   always_ff @(posedge nclk or negedge arst_n) begin
      if (!arst_n) begin
         ex3_b_frac <= '0;
         ex3_b_zero <= 1'b0;
         prod_z     <= 1'b0;
         ex3_effsub <= 1'b0;
      end else if (ex2_act) begin
         ex3_b_frac <= b_frac;
         ex3_b_zero <= b_zero;
         prod_z     <= prod_zero;
         ex3_effsub <= effsub;
      end
   end

   // A zero product or an addend far above it passes B straight through
   assign sel_byp = prod_z | (ex3_ovf & ~ex3_b_zero);
   assign sh_ovf  = sel_byp;
   assign sh_unf  = ex3_unf & ~prod_z;

   always_comb begin
      if (sel_byp) begin
         base = {ex3_b_frac, {(`ALG_RES_W - `ALG_FRAC_W){1'b0}}};
      end else if (sh_unf | ex3_b_zero) begin
         base = '0;
      end else begin
         base = ex3_shifted;
      end
   end

   assign res          = base ^ {`ALG_RES_W{ex3_effsub}};
   assign effsub_eac_b = ~ex3_effsub;

endmodule

// ==== rtl/fu_alg.sv ====
/*
 * FMA addend aligner
 * Shifts the B operand into line with the product over ex2 and ex3
 * and reports the sticky bit in ex4
 */
`timescale 1ns/1ns

module fu_alg (
   input  logic            nclk,
   input  logic            arst_n,
   input  logic            ex2_act,
   input  alg_pkg::expo_t  a_expo,
   input  alg_pkg::expo_t  c_expo,
   input  alg_pkg::expo_t  b_expo,
   input  alg_pkg::frac_t  b_frac,
   input  logic            b_zero,
   input  logic            prod_zero,
   input  logic            effsub,
   output alg_pkg::res_t   res,
   output logic            sel_byp,
   output logic            sh_ovf,
   output logic            sh_unf,
   output logic            prod_z,
   output logic            effsub_eac_b,
   output logic            sticky
);

   alg_pkg::fine_t    fine;
   alg_pkg::coarse_t  ex3_coarse;
   logic              ex3_ovf;
   logic              ex3_unf;
   alg_pkg::lvl2_t    ex3_lvl2;
   alg_pkg::res_t     ex3_shifted;
   logic              ex3_b_zero;

   alg_shift_amount u_sha (
      .nclk       (nclk),
      .arst_n     (arst_n),
      .ex2_act    (ex2_act),
      .a_expo     (a_expo),
      .c_expo     (c_expo),
      .b_expo     (b_expo),
      .fine       (fine),
      .ex3_coarse (ex3_coarse),
      .ex3_ovf    (ex3_ovf),
      .ex3_unf    (ex3_unf)
   );

   alg_shift_fine u_fine (
      .nclk     (nclk),
      .arst_n   (arst_n),
      .ex2_act  (ex2_act),
      .b_frac   (b_frac),
      .fine     (fine),
      .ex3_lvl2 (ex3_lvl2)
   );

   alg_shift_coarse u_coarse (
      .ex3_lvl2    (ex3_lvl2),
      .ex3_coarse  (ex3_coarse),
      .ex3_shifted (ex3_shifted)
   );

   alg_sticky u_sticky (
      .nclk        (nclk),
      .arst_n      (arst_n),
      .ex2_act     (ex2_act),
      .ex3_lvl2    (ex3_lvl2),
      .ex3_coarse  (ex3_coarse),
      .ex3_sel_byp (sel_byp),
      .ex3_sh_unf  (sh_unf),
      .ex3_b_zero  (ex3_b_zero),
      .sticky      (sticky)
   );

   alg_result_select u_sel (
      .nclk         (nclk),
      .arst_n       (arst_n),
      .ex2_act      (ex2_act),
      .b_frac       (b_frac),
      .b_zero       (b_zero),
      .prod_zero    (prod_zero),
      .effsub       (effsub),
      .ex3_ovf      (ex3_ovf),
      .ex3_unf      (ex3_unf),
      .ex3_shifted  (ex3_shifted),
      .res          (res),
      .sel_byp      (sel_byp),
      .sh_ovf       (sh_ovf),
      .sh_unf       (sh_unf),
      .prod_z       (prod_z),
      .effsub_eac_b (effsub_eac_b),
      .ex3_b_zero   (ex3_b_zero)
   );

endmodule

// ==== verif/tb_fu_alg.sv ====
/*
 * Testbench for the FMA addend aligner
 * Random operands checked against a cycle model of the ex3 and ex4 outputs
 */
`timescale 1ns/1ns
`include "alg_settings.svh"

module tb_fu_alg;

   localparam int n_cycles     = 3000;
   localparam int rst_cycles   = 10;
   localparam int idle_cycles  = 4;
   localparam int drain_cycles = 4;
   localparam int timeout_ns   = (n_cycles + rst_cycles + idle_cycles + drain_cycles) * 10 + 500;

   logic            nclk;
   logic            arst_n;
   logic            ex2_act;
   alg_pkg::expo_t  a_expo;
   alg_pkg::expo_t  c_expo;
   alg_pkg::expo_t  b_expo;
   alg_pkg::frac_t  b_frac;
   logic            b_zero;
   logic            prod_zero;
   logic            effsub;
   alg_pkg::res_t   res;
   logic            sel_byp;
   logic            sh_ovf;
   logic            sh_unf;
   logic            prod_z;
   logic            effsub_eac_b;
   logic            sticky;

   // The model keeps one set of values for ex3 and one sticky bit for ex4
   alg_pkg::res_t   m_res;
   logic            m_sel_byp;
   logic            m_sh_unf;
   logic            m_prod_z;
   logic            m_effsub_eac_b;
   logic            m_act3;
   logic            m_sticky_ex3;
   logic            m_sticky;

   integer          seed = 79;
   int              n_unf = 0;
   int              n_ovf = 0;
   int              n_part = 0;

   fu_alg DUT (
      .nclk         (nclk),
      .arst_n       (arst_n),
      .ex2_act      (ex2_act),
      .a_expo       (a_expo),
      .c_expo       (c_expo),
      .b_expo       (b_expo),
      .b_frac       (b_frac),
      .b_zero       (b_zero),
      .prod_zero    (prod_zero),
      .effsub       (effsub),
      .res          (res),
      .sel_byp      (sel_byp),
      .sh_ovf       (sh_ovf),
      .sh_unf       (sh_unf),
      .prod_z       (prod_z),
      .effsub_eac_b (effsub_eac_b),
      .sticky       (sticky)
   );

   always #5 nclk = ~nclk;

   // Result bit p holds B bit (p - sha) unless the bypass puts B bit p there
   function automatic alg_pkg::res_t expect_res(input alg_pkg::frac_t b, input int sha,
                                                input logic byp, input logic zero,
                                                input logic inv);
      alg_pkg::res_t r;
      int            q;
      r = '0;
      for (int p = 0; p < `ALG_RES_W; p++) begin
         if (byp) q = p;
         else if (zero) q = -1;
         else q = p - sha;
         if (q >= 0 && q < `ALG_FRAC_W) r[p] = b[q];
      end
      if (inv) r = ~r;
      return r;
   endfunction

   function automatic logic expect_sticky(input alg_pkg::frac_t b, input int sha,
                                          input logic byp, input logic unf, input logic bz);
      logic s;
      s = 1'b0;
      if (!(byp || bz)) begin
         if (unf) s = |b;
         else begin
            for (int q = 0; q < `ALG_FRAC_W; q++) begin
               if (q + sha > `ALG_SHIFT_MAX) s = s | b[q];
            end
         end
      end
      return s;
   endfunction

   task automatic check_res(input string name, input alg_pkg::res_t got,
                            input alg_pkg::res_t exp);
      if (got !== exp) begin
         $display("FAILED %0t: %s is %h, expected %h", $time, name, got, exp);
         $display("Result: FAILED");
         $fatal(1);
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("FAILED %0t: %s is %b, expected %b", $time, name, got, exp);
         $display("Result: FAILED");
         $fatal(1);
      end
   endtask

   // The shift target runs from -30 to 200 and the exponents are picked around the bias
   task automatic drive_random();
      int          t;
      int          a;
      int          c;
      int          b;
      logic [63:0] rnd;
      t = -30 + int'($unsigned($random(seed)) % 231);
      a = 973 + int'($unsigned($random(seed)) % 101);
      c = 973 + int'($unsigned($random(seed)) % 101);
      b = a + c - `ALG_EXPO_BIAS + `ALG_SHIFT_OFFSET - t;
      rnd = {$random(seed), $random(seed)};
      if (($random(seed) & 7) == 0) rnd = '0;
      ex2_act   <= ($random(seed) & 3) != 0;
      prod_zero <= ($random(seed) & 7) == 0;
      effsub    <= ($random(seed) & 1) != 0;
      a_expo    <= alg_pkg::expo_t'(a);
      c_expo    <= alg_pkg::expo_t'(c);
      b_expo    <= alg_pkg::expo_t'(b);
      b_frac    <= rnd[`ALG_FRAC_W-1:0];
      b_zero    <= (rnd[`ALG_FRAC_W-1:0] == '0);
   endtask

   always @(posedge nclk) begin : model
      int   sha;
      logic byp;
      logic sunf;
      if (!arst_n) begin
         m_res          <= '0;
         m_sel_byp      <= 1'b0;
         m_sh_unf       <= 1'b0;
         m_prod_z       <= 1'b0;
         m_effsub_eac_b <= 1'b1;
         m_act3         <= 1'b0;
         m_sticky_ex3   <= 1'b0;
         m_sticky       <= 1'b0;
      end else begin
         if (m_act3) m_sticky <= m_sticky_ex3;
         m_act3 <= ex2_act;
         if (ex2_act) begin
            sha  = int'(a_expo) + int'(c_expo) - int'(b_expo)
                   - `ALG_EXPO_BIAS + `ALG_SHIFT_OFFSET;
            byp  = prod_zero | ((sha < 0) & ~b_zero);
            sunf = (sha > `ALG_SHIFT_MAX) & ~prod_zero;
            m_res          <= expect_res(b_frac, sha, byp, sunf | b_zero, effsub);
            m_sel_byp      <= byp;
            m_sh_unf       <= sunf;
            m_prod_z       <= prod_zero;
            m_effsub_eac_b <= ~effsub;
            m_sticky_ex3   <= expect_sticky(b_frac, sha, byp, sunf, b_zero);
            if (sunf && !b_zero) n_unf++;
            if (sha < 0 && !prod_zero && !b_zero) n_ovf++;
            if (!byp && !b_zero && sha > 110 && sha <= `ALG_SHIFT_MAX) n_part++;
         end
      end
   end

   always @(negedge nclk) begin
      if (arst_n) begin
         check_res("res", res, m_res);
         check_flag("sel_byp", sel_byp, m_sel_byp);
         check_flag("sh_ovf", sh_ovf, m_sel_byp);
         check_flag("sh_unf", sh_unf, m_sh_unf);
         check_flag("prod_z", prod_z, m_prod_z);
         check_flag("effsub_eac_b", effsub_eac_b, m_effsub_eac_b);
         check_flag("sticky", sticky, m_sticky);
      end
   end

   initial begin
      nclk      = 1'b0;
      arst_n    = 1'b0;
      ex2_act   = 1'b0;
      a_expo    = '0;
      c_expo    = '0;
      b_expo    = '0;
      b_frac    = '0;
      b_zero    = 1'b1;
      prod_zero = 1'b0;
      effsub    = 1'b0;
      repeat (rst_cycles) @(posedge nclk);
      arst_n <= 1'b1;
      // A few idle cycles show the reset values on the outputs
      repeat (idle_cycles) @(posedge nclk);
      repeat (n_cycles) begin
         @(posedge nclk);
         drive_random();
      end
      @(posedge nclk);
      ex2_act <= 1'b0;
      repeat (drain_cycles) @(posedge nclk);
      if (n_unf > 0 && n_ovf > 0 && n_part > 0) begin
         $display("Result: PASSED");
         $finish;
      end else begin
         $display("Error: a shift range was never exercised");
         $display("Result: FAILED");
         $fatal(1);
      end
   end

   initial begin
      #(timeout_ns);
      $display("Error: the run did not finish within %0d ns", timeout_ns);
      $display("Result: FAILED");
      $fatal(1);
   end

endmodule

// ==== filelist.f ====
+incdir+rtl
rtl/alg_pkg.sv
rtl/alg_shift_amount.sv
rtl/alg_shift_fine.sv
rtl/alg_shift_coarse.sv
rtl/alg_sticky.sv
rtl/alg_result_select.sv
rtl/fu_alg.sv
verif/tb_fu_alg.sv

// ==== Makefile ====
# Verilator build and run for the FMA addend aligner testbench

VERILATOR ?= verilator
TOP       ?= tb_fu_alg
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ns
PASS_MSG  ?= Result: PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR) -o V$(TOP)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
